// File: vlog.f
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
tb/tb_rv_checker.sv
tb/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_rv_core \
    --Mdir obj_dir -o tb_rv_core \
    -f vlog.f

./obj_dir/tb_rv_core > sim.log
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    import rv_pipe_pkg::*;

    localparam int PROG_WORDS     = 48;
    localparam int EXP_COUNT      = 29;
    localparam int TIMEOUT_CYCLES = 40 * PROG_WORDS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic        imem_cyc;
    logic [31:0] imem_data;
    logic        imem_ack;
    wb_event_t   wb;
    wb_event_t   expected;
    int          trace_index;
    logic        trace_done;
    int          value_errors;
    int          other_errors;
    int          cycles;
    logic        timed_out;
    logic [31:0] rng;

    // Program from address 0 with four words per line
    logic [31:0] prog [PROG_WORDS] = '{
        32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h40208233,   // addi, addi, add, sub
        32'h0020F2B3, 32'h0020E333, 32'h0020C3B3, 32'h00112433,   // and, or, xor, slt
        32'h001134B3, 32'h00409513, 32'h40115593, 32'h01C15613,   // sltu, slli, srai, srli
        32'h123456B7, 32'h00001717, 32'h0FF6C793, 32'h00809833,   // lui, auipc, xori, sll
        32'h408158B3, 32'h00A35933, 32'hFFE12993, 32'h0040BA13,   // sra, srl, slti, sltiu
        32'h0100EA93, 32'h0F017B13, 32'h00108463, 32'h00100B93,   // ori, andi, beq taken
        32'h00209463, 32'h00200B93, 32'h00114463, 32'h00300B93,   // bne, blt
        32'h0020D463, 32'h00400B93, 32'h0020E463, 32'h00500B93,   // bge, bltu
        32'h00117463, 32'h00600B93, 32'h00208463, 32'h00700C13,   // bgeu, beq not taken
        32'h00116463, 32'h001C0C93, 32'h010000EF, 32'h00900D13,   // bltu not taken, call
        32'h0140006F, 32'h00100D93, 32'h00408E13, 32'h00008EE7,   // jump over, subroutine
        32'h00200D93, 32'h01DE0F67, 32'h00300D93, 32'h0000006F    // jalr to 0xBC, end loop
    };

    // Writebacks in program order
    wb_event_t exp_trace [EXP_COUNT] = '{
        '{1'b1, 5'd1,  32'h00000005}, '{1'b1, 5'd2,  32'hFFFFFFFD}, '{1'b1, 5'd3,  32'h00000002},
        '{1'b1, 5'd4,  32'h00000008}, '{1'b1, 5'd5,  32'h00000005}, '{1'b1, 5'd6,  32'hFFFFFFFD},
        '{1'b1, 5'd7,  32'hFFFFFFF8}, '{1'b1, 5'd8,  32'h00000001}, '{1'b1, 5'd9,  32'h00000000},
        '{1'b1, 5'd10, 32'h00000050}, '{1'b1, 5'd11, 32'hFFFFFFFE}, '{1'b1, 5'd12, 32'h0000000F},
        '{1'b1, 5'd13, 32'h12345000}, '{1'b1, 5'd14, 32'h00001034}, '{1'b1, 5'd15, 32'h123450FF},
        '{1'b1, 5'd16, 32'h0000000A}, '{1'b1, 5'd17, 32'hFFFFFFFE}, '{1'b1, 5'd18, 32'h0000FFFF},
        '{1'b1, 5'd19, 32'h00000001}, '{1'b1, 5'd20, 32'h00000000}, '{1'b1, 5'd21, 32'h00000015},
        '{1'b1, 5'd22, 32'h000000F0}, '{1'b1, 5'd24, 32'h00000007}, '{1'b1, 5'd25, 32'h00000008},
        '{1'b1, 5'd1,  32'h0000009C}, '{1'b1, 5'd28, 32'h000000A0}, '{1'b1, 5'd29, 32'h000000B0},
        '{1'b1, 5'd26, 32'h00000009}, '{1'b1, 5'd30, 32'h000000B8}
    };

    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Fill words end in 2'b00 and never form a 32-bit opcode
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < 32'(PROG_WORDS * 4))
            return prog[addr[7:2]];
        return {addr[31:2], 2'b00};
    endfunction

    assign expected = (trace_index < EXP_COUNT) ? exp_trace[trace_index[4:0]] : '0;

    rv_core UUT
    (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .o_imem_addr (imem_addr),
        .o_imem_cyc  (imem_cyc),
        .i_imem_data (imem_data),
        .i_imem_ack  (imem_ack),
        .o_wb        (wb)
    );

    tb_rv_checker tb_rv_checker
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_imem_addr    (imem_addr),
        .i_imem_cyc     (imem_cyc),
        .i_imem_ack     (imem_ack),
        .i_wb           (wb),
        .i_expected     (expected),
        .i_count        (EXP_COUNT),
        .o_index        (trace_index),
        .o_done         (trace_done),
        .o_value_errors (value_errors),
        .o_other_errors (other_errors)
    );

    always #50 clk = ~clk;

    // Instruction memory driven on the falling edge
    initial
    begin
        imem_data = '0;
        imem_ack  = 1'b0;
        rng       = 32'd914;
        forever
        begin
            @(negedge clk);
            rng       = xorshift_next(rng);
            imem_ack  = (rng % 32'd3) != 32'd0;     // About one wait state in three
            imem_data = fetch_word(imem_addr);
        end
    end

    initial
    begin
        rst_n     = 1'b0;
        timed_out = 1'b0;
        cycles    = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (!trace_done && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!trace_done)
        begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d writebacks seen after %0d cycles",
                     trace_index, EXP_COUNT, cycles);
        end
        else
            repeat (20) @(negedge clk);     // Stray writebacks would show here
        $display("Error counts: value %0d, other %0d, timeout %0d",
                 value_errors, other_errors, timed_out);
        if (value_errors == 0 && other_errors == 0 && !timed_out)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: tb/tb_rv_checker.sv
`timescale 1ns/1ps

`include "rv_core_settings.svh"

module tb_rv_checker
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [31:0]            i_imem_addr,
    input  logic                   i_imem_cyc,
    input  logic                   i_imem_ack,
    input  rv_pipe_pkg::wb_event_t i_wb,
    input  rv_pipe_pkg::wb_event_t i_expected,
    input  int                     i_count,
    output int                     o_index,
    output logic                   o_done,
    output int                     o_value_errors,
    output int                     o_other_errors
);

    logic req_seen;
    logic xfer_seen;
    int   edges_since_xfer;      // Saturates at 3

    assign o_done = (o_index == i_count);

    always @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_index          = 0;
            o_value_errors   = 0;
            o_other_errors   = 0;
            req_seen         = 1'b0;
            xfer_seen        = 1'b0;
            edges_since_xfer = 0;
        end
        else
        begin
            if (i_imem_cyc && !req_seen)
            begin
                req_seen = 1'b1;
                if (i_imem_addr !== `RV_RESET_ADDR)
                begin
                    $display("Error o_imem_addr: expected %h, actual %h",
                             `RV_RESET_ADDR, i_imem_addr);
                    o_value_errors++;
                end
            end
            if (xfer_seen && edges_since_xfer < 3)
                edges_since_xfer++;
            if (i_wb.valid)
            begin
                // Fetch, decode and execute each take one edge
                if (!xfer_seen || edges_since_xfer < 3)
                begin
                    $display("Writeback reported before the first instruction could complete");
                    o_other_errors++;
                end
                else if (o_index >= i_count)
                begin
                    $display("Unexpected writeback beyond the expected trace: rd %h data %h",
                             i_wb.rd, i_wb.data);
                    o_other_errors++;
                end
                else
                begin
                    if (i_wb.rd !== i_expected.rd)
                    begin
                        $display("Error o_wb.rd (entry %0d): expected %h, actual %h",
                                 o_index, i_expected.rd, i_wb.rd);
                        o_value_errors++;
                    end
                    if (i_wb.data !== i_expected.data)
                    begin
                        $display("Error o_wb.data (entry %0d): expected %h, actual %h",
                                 o_index, i_expected.data, i_wb.data);
                        o_value_errors++;
                    end
                    o_index++;
                end
            end
            if (i_imem_cyc && i_imem_ack)
                xfer_seen = 1'b1;
        end
    end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

module rv_core
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    output logic [31:0]            o_imem_addr,
    output logic                   o_imem_cyc,
    input  logic [31:0]            i_imem_data,
    input  logic                   i_imem_ack,
    output rv_pipe_pkg::wb_event_t o_wb
);

    import rv_pipe_pkg::*;

    fetch_out_t  fetch;
    decode_out_t dec;
    exec_out_t   exec;
    redirect_t   redirect;      // From execute to fetch and decode
    logic        stall;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    rv_fetch u_fetch
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .i_imem_data (i_imem_data),
        .i_imem_ack  (i_imem_ack),
        .o_imem_addr (o_imem_addr),
        .o_imem_cyc  (o_imem_cyc),
        .o_fetch     (fetch)
    );

    rv_decode u_decode
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_fetch    (fetch),
        .i_redirect (redirect),
        .i_exec     (exec),
        .i_rs1_val  (rs1_val),
        .i_rs2_val  (rs2_val),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_stall    (stall),
        .o_dec      (dec)
    );

    rv_execute u_execute
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_dec      (dec),
        .o_redirect (redirect),
        .o_exec     (exec)
    );

    rv_result u_result
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_exec     (exec),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .o_wb       (o_wb)
    );

endmodule

// File: hw/rv_result.sv
`timescale 1ns/1ps

`include "rv_core_settings.svh"

module rv_result
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_pipe_pkg::exec_out_t i_exec,
    input  logic [4:0]             i_rs1_addr,
    input  logic [4:0]             i_rs2_addr,
    output logic [31:0]            o_rs1_val,
    output logic [31:0]            o_rs2_val,
    output rv_pipe_pkg::wb_event_t o_wb
);

    logic [31:0] regs [`RV_NREGS];
    logic        wr_en;

    // x0 is never written
    assign wr_en = i_exec.valid & i_exec.wb_en & (i_exec.rd != 5'd0);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[i_exec.rd] <= i_exec.data;
    end

    // Same cycle write goes straight through to the readers
    assign o_rs1_val = (i_rs1_addr == 5'd0) ? 32'd0 :
                       (wr_en && i_exec.rd == i_rs1_addr) ? i_exec.data : regs[i_rs1_addr];
    assign o_rs2_val = (i_rs2_addr == 5'd0) ? 32'd0 :
                       (wr_en && i_exec.rd == i_rs2_addr) ? i_exec.data : regs[i_rs2_addr];

    assign o_wb = '{valid: wr_en, rd: i_exec.rd, data: i_exec.data};

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  rv_pipe_pkg::decode_out_t i_dec,
    output rv_pipe_pkg::redirect_t   o_redirect,
    output rv_pipe_pkg::exec_out_t   o_exec
);

    import rv_isa_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        taken;
    logic        is_jump;
    logic [31:0] br_target;
    logic [31:0] link;
    logic        exe_valid_q;
    logic [4:0]  exe_rd_q;
    logic [31:0] exe_data_q;
    logic        exe_wb_en_q;

    assign op_a = i_dec.a_sel_pc  ? i_dec.pc  : i_dec.rs1_val;
    assign op_b = i_dec.b_sel_imm ? i_dec.imm : i_dec.rs2_val;

    always_comb
    begin
        case (i_dec.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            default:  alu_res = op_b;
        endcase
    end

    // Branches compare the register values and not the ALU operands
    always_comb
    begin
        case (i_dec.br_op)
            BR_EQ:   taken = (i_dec.rs1_val == i_dec.rs2_val);
            BR_NE:   taken = (i_dec.rs1_val != i_dec.rs2_val);
            BR_LT:   taken = ($signed(i_dec.rs1_val) < $signed(i_dec.rs2_val));
            BR_GE:   taken = ($signed(i_dec.rs1_val) >= $signed(i_dec.rs2_val));
            BR_LTU:  taken = (i_dec.rs1_val < i_dec.rs2_val);
            BR_GEU:  taken = (i_dec.rs1_val >= i_dec.rs2_val);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump   = (i_dec.br_op == BR_JAL) || (i_dec.br_op == BR_JALR);
    assign br_target = (i_dec.br_op == BR_JALR) ? ((i_dec.rs1_val + i_dec.imm) & ~32'd1)
                                                : (i_dec.pc + i_dec.imm);
    assign link      = i_dec.pc + 32'd4;

    assign o_redirect = '{select: i_dec.valid & taken, target: br_target};

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            exe_valid_q <= 1'b0;
        else
            exe_valid_q <= i_dec.valid;
    end

    always_ff @(posedge i_clk)
    begin
        exe_rd_q    <= i_dec.rd;
        exe_data_q  <= is_jump ? link : alu_res;    // Link value for jumps
        exe_wb_en_q <= i_dec.wb_en;
    end

    assign o_exec = '{valid: exe_valid_q, rd: exe_rd_q, data: exe_data_q, wb_en: exe_wb_en_q};

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ps

`include "rv_core_settings.svh"

module rv_decode
(
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  rv_pipe_pkg::fetch_out_t  i_fetch,
    input  rv_pipe_pkg::redirect_t   i_redirect,
    input  rv_pipe_pkg::exec_out_t   i_exec,
    input  logic [31:0]              i_rs1_val,
    input  logic [31:0]              i_rs2_val,
    output logic [4:0]               o_rs1_addr,
    output logic [4:0]               o_rs2_addr,
    output logic                     o_stall,
    output rv_pipe_pkg::decode_out_t o_dec
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [31:0]                  instr;
    rv_opcode_e                   opcode;
    logic [2:0]                   funct3;
    logic                         f7_zero;
    logic                         alt;
    logic [$clog2(`RV_NREGS)-1:0] rs1;
    logic [$clog2(`RV_NREGS)-1:0] rs2;
    logic [31:0]                  imm_i;
    logic [31:0]                  imm_u;
    logic [31:0]                  imm_b;
    logic [31:0]                  imm_j;
    logic                         legal;
    logic                         use_rs1;
    logic                         use_rs2;
    logic                         rs1_chk;
    logic                         rs2_chk;
    logic                         hz_dec;
    logic                         hz_exe;
    decode_out_t                  dec_d;
    decode_out_t                  dec_q;
    logic                         dec_valid_q;

    function automatic rv_alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr   = i_fetch.instr;
    assign opcode  = rv_opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign f7_zero = (instr[31:25] == 7'b0000000);
    assign alt     = (instr[31:25] == 7'b0100000);
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        legal           = 1'b0;
        use_rs1         = 1'b0;
        use_rs2         = 1'b0;
        dec_d           = '0;
        dec_d.pc        = i_fetch.pc;
        dec_d.rs1_val   = i_rs1_val;
        dec_d.rs2_val   = i_rs2_val;
        dec_d.rd        = instr[11:7];
        dec_d.alu_op    = ALU_ADD;
        dec_d.br_op     = BR_NONE;
        dec_d.b_sel_imm = 1'b1;
        dec_d.imm       = imm_i;
        case (opcode)
            OPC_LUI:
            begin
                legal        = 1'b1;
                dec_d.alu_op = ALU_PASS_B;
                dec_d.imm    = imm_u;
                dec_d.wb_en  = 1'b1;
            end
            OPC_AUIPC:
            begin
                legal          = 1'b1;
                dec_d.a_sel_pc = 1'b1;
                dec_d.imm      = imm_u;
                dec_d.wb_en    = 1'b1;
            end
            OPC_JAL:
            begin
                legal       = 1'b1;
                dec_d.br_op = BR_JAL;
                dec_d.imm   = imm_j;
                dec_d.wb_en = 1'b1;
            end
            OPC_JALR:
            begin
                legal       = (funct3 == 3'b000);
                use_rs1     = 1'b1;
                dec_d.br_op = BR_JALR;
                dec_d.wb_en = 1'b1;
            end
            OPC_BRANCH:
            begin
                legal     = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec_d.imm = imm_b;
                case (funct3)
                    3'b000:  dec_d.br_op = BR_EQ;
                    3'b001:  dec_d.br_op = BR_NE;
                    3'b100:  dec_d.br_op = BR_LT;
                    3'b101:  dec_d.br_op = BR_GE;
                    3'b110:  dec_d.br_op = BR_LTU;
                    3'b111:  dec_d.br_op = BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                use_rs1      = 1'b1;
                dec_d.wb_en  = 1'b1;
                dec_d.alu_op = alu_sel(funct3, alt && funct3 == 3'b101);    // Only SRAI
                if (funct3 == 3'b001)
                    legal = f7_zero;
                else if (funct3 == 3'b101)
                    legal = f7_zero | alt;
                else
                    legal = 1'b1;
            end
            OPC_OP:
            begin
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
                dec_d.b_sel_imm = 1'b0;
                dec_d.wb_en     = 1'b1;
                dec_d.alu_op    = alu_sel(funct3, alt);
                legal = f7_zero | (alt & (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default:
                legal = 1'b0;   // Decodes as a bubble
        endcase
    end

    // Stall on pending writes in the decode and execute registers
    assign rs1_chk = legal & use_rs1 & (rs1 != '0);
    assign rs2_chk = legal & use_rs2 & (rs2 != '0);
    assign hz_dec  = dec_valid_q & dec_q.wb_en &
                     ((rs1_chk & (rs1 == dec_q.rd)) | (rs2_chk & (rs2 == dec_q.rd)));
    assign hz_exe  = i_exec.valid & i_exec.wb_en &
                     ((rs1_chk & (rs1 == i_exec.rd)) | (rs2_chk & (rs2 == i_exec.rd)));
    assign o_stall = i_fetch.valid & (hz_dec | hz_exe);

    assign o_rs1_addr = rs1;
    assign o_rs2_addr = rs2;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            dec_valid_q <= 1'b0;
        else
            dec_valid_q <= i_fetch.valid & legal & ~o_stall & ~i_redirect.select;
    end

    always_ff @(posedge i_clk)
    begin
        dec_q <= dec_d;
    end

    always_comb
    begin
        o_dec       = dec_q;
        o_dec.valid = dec_valid_q;
    end

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_core_settings.svh"

module rv_fetch
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  rv_pipe_pkg::redirect_t  i_redirect,
    input  logic [31:0]             i_imem_data,
    input  logic                    i_imem_ack,
    output logic [31:0]             o_imem_addr,
    output logic                    o_imem_cyc,
    output rv_pipe_pkg::fetch_out_t o_fetch
);

    logic        run_q;         // Set on the first edge after reset
    logic [31:0] pc_q;
    logic        valid_q;
    logic [31:0] instr_pc_q;
    logic [31:0] instr_q;
    logic        xfer;

    assign o_imem_cyc  = run_q & ~i_stall & ~i_redirect.select;
    assign o_imem_addr = pc_q;

    // Word belongs to this cycle's address
    assign xfer = o_imem_cyc & i_imem_ack;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            run_q   <= 1'b0;
            pc_q    <= `RV_RESET_ADDR;
            valid_q <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            if (i_redirect.select)
            begin
                pc_q    <= i_redirect.target;
                valid_q <= 1'b0;        // Drop the shadow instruction
            end
            else if (!i_stall)
            begin
                valid_q <= xfer;
                if (xfer)
                    pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (xfer)
        begin
            instr_pc_q <= pc_q;
            instr_q    <= i_imem_data;
        end
    end

    assign o_fetch = '{valid: valid_q, pc: instr_pc_q, instr: instr_q};

endmodule

// File: hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_out_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        rv_isa_pkg::rv_alu_op_e alu_op;
        rv_isa_pkg::rv_br_op_e  br_op;
        logic                   a_sel_pc;     // AUIPC
        logic                   b_sel_imm;
        logic [31:0]            rs1_val;
        logic [31:0]            rs2_val;
        logic [31:0]            imm;
        logic [4:0]             rd;
        logic                   wb_en;
    } decode_out_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        wb_en;
    } exec_out_t;

    // Writeback report on the top level port
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_event_t;

    typedef struct packed {
        logic        select;    // One cycle pulse
        logic [31:0] target;
    } redirect_t;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcode field in instruction bits [6:0]
    typedef enum logic [6:0]
    {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [3:0]
    {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10     // LUI
    } rv_alu_op_e;

    // Nine operations need four bits
    typedef enum logic [3:0]
    {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } rv_br_op_e;

endpackage

// File: include/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// First fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

// Integer registers including x0
`define RV_NREGS 32

`endif
